// File: hw/dpram_defines.svh
`ifndef DPRAM_DEFINES_SVH
`define DPRAM_DEFINES_SVH

// Word and byte address widths.
`define DPRAM_DATA_W 32
`define DPRAM_ADDR_W 32

// Byte lanes per word.
`define DPRAM_BYTES 4

// Each bank holds half of the 1024-word memory.
`define DPRAM_BANK_DEPTH 512
`define DPRAM_ROW_W 9

`endif

// File: hw/dpram_pkg.sv
`include "dpram_defines.svh"

package dpram_pkg;

  typedef logic [`DPRAM_DATA_W-1:0] data_t;
  typedef logic [`DPRAM_BYTES-1:0]  be_t;

  // Word-interleaved split with bit 2 picking the bank.
  typedef struct packed {
    logic [`DPRAM_ADDR_W-4:0] row;
    logic                     bank_sel;
    logic [1:0]               byte_off;
  } addr_fields_t;

  typedef union packed {
    logic [`DPRAM_ADDR_W-1:0] flat;
    addr_fields_t             f;
  } addr_u;

endpackage

// File: hw/bank_port_if.sv
`timescale 1ns/1ps

interface bank_port_if
  import dpram_pkg::*;
();

  logic  req;
  logic  we;
  addr_u addr;
  be_t   be;
  data_t wdata;
  data_t rdata;
  logic  busy;
  logic  resp;

  modport router (
    output req, we, addr, be, wdata,
    input  rdata, busy, resp
  );

  modport bank (
    input  req, we, addr, be, wdata,
    output rdata, busy, resp
  );

endinterface

// File: hw/bank_ram.sv
`timescale 1ns/1ps
`include "dpram_defines.svh"

module bank_ram (
  input  logic                     clk_i,
  input  logic [`DPRAM_ROW_W-1:0]  a_row_i,
  input  logic                     a_we_i,
  input  logic [`DPRAM_DATA_W-1:0] a_wdata_i,
  output logic [`DPRAM_DATA_W-1:0] a_rdata_o,
  input  logic [`DPRAM_ROW_W-1:0]  b_row_i,
  input  logic                     b_we_i,
  input  logic [`DPRAM_DATA_W-1:0] b_wdata_i,
  output logic [`DPRAM_DATA_W-1:0] b_rdata_o
);

  logic [`DPRAM_DATA_W-1:0] mem [`DPRAM_BANK_DEPTH];

  // Read-before-write on both ports, one cycle of read latency.
  always_ff @(posedge clk_i)
  begin
    if (a_we_i)
    begin
      mem[a_row_i] <= a_wdata_i;
    end
    if (b_we_i)
    begin
      mem[b_row_i] <= b_wdata_i;
    end
    a_rdata_o <= mem[a_row_i];
    b_rdata_o <= mem[b_row_i];
  end

endmodule

// File: hw/bank_port_ctrl.sv
`timescale 1ns/1ps
`include "dpram_defines.svh"

module bank_port_ctrl
  import dpram_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  bank_port_if.bank               port_i,
  output logic [`DPRAM_ROW_W-1:0] ram_row_o,
  output logic                    ram_we_o,
  output data_t                   ram_wdata_o,
  input  data_t                   ram_rdata_i
);

  logic                    full_wr;
  logic                    part_wr;
  logic                    rd;
  logic                    wb_q;
  logic                    resp_q;
  logic [`DPRAM_ROW_W-1:0] row_q;
  logic [1:0]              off_q;
  be_t                     be_q;
  data_t                   wdata_q;
  data_t                   merged;

  assign full_wr = port_i.req & port_i.we & (port_i.be == '1);
  assign part_wr = port_i.req & port_i.we & (port_i.be != '1);
  assign rd      = port_i.req & ~port_i.we;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wb_q   <= 1'b0;
      resp_q <= 1'b0;
    end
    else
    begin
      wb_q   <= part_wr;
      resp_q <= rd;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (port_i.req)
    begin
      row_q   <= port_i.addr.f.row[`DPRAM_ROW_W-1:0];
      off_q   <= port_i.addr.f.byte_off;
      be_q    <= port_i.be;
      wdata_q <= port_i.wdata;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Write-back merge moves the enabled bytes up by the offset.
  //////////////////////////////////////////////////////////////////////////
  always_comb
  begin
    int lane;
    merged = ram_rdata_i;
    for (int i = 0; i < `DPRAM_BYTES; i++)
    begin
      lane = i + int'(off_q);
      // Lanes past the top of the word are dropped.
      if (be_q[i] && (lane < `DPRAM_BYTES))
        merged[lane*8 +: 8] = wdata_q[i*8 +: 8];
    end
  end

  always_comb
  begin
    if (wb_q)
    begin
      ram_row_o   = row_q;
      ram_we_o    = 1'b1;
      ram_wdata_o = merged;
    end
    else
    begin
      ram_row_o   = port_i.addr.f.row[`DPRAM_ROW_W-1:0];
      ram_we_o    = full_wr;
      ram_wdata_o = port_i.wdata;
    end
  end

  assign port_i.busy  = wb_q;
  assign port_i.resp  = resp_q;
  assign port_i.rdata = ram_rdata_i >> {off_q, 3'b000};

  // The router must hold the port off during the write-back cycle.
  a_no_req_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    port_i.busy |-> !port_i.req)
    else $error("request accepted during write-back");

endmodule

// File: hw/bus_router.sv
`timescale 1ns/1ps

module bus_router
  import dpram_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        s0_req_i,
  input  logic        s0_we_i,
  input  addr_u       s0_addr_i,
  input  be_t         s0_be_i,
  input  data_t       s0_wdata_i,
  output logic        s0_ack_o,
  output logic        s0_resp_o,
  output data_t       s0_rdata_o,
  input  logic        s1_req_i,
  input  logic        s1_we_i,
  input  addr_u       s1_addr_i,
  input  be_t         s1_be_i,
  input  data_t       s1_wdata_i,
  output logic        s1_ack_o,
  output logic        s1_resp_o,
  output data_t       s1_rdata_o,
  bank_port_if.router bank0_o,
  bank_port_if.router bank1_o
);

  logic       s0_bank;
  logic       s1_bank;
  logic       s1_grant;
  logic       s0_owns_b0;
  logic       s0_owns_b1;
  logic [1:0] own_q;

  assign s0_bank = s0_addr_i.f.bank_sel;
  assign s1_bank = s1_addr_i.f.bank_sel;

  // Slot 0 always wins its bank, slot 1 yields on a clash.
  assign s1_grant = s1_req_i & ~(s0_req_i & (s0_bank == s1_bank));

  assign s0_ack_o = s0_req_i & ~(s0_bank ? bank1_o.busy : bank0_o.busy);
  assign s1_ack_o = s1_grant & ~(s1_bank ? bank1_o.busy : bank0_o.busy);

  assign s0_owns_b0 = s0_req_i & ~s0_bank;
  assign s0_owns_b1 = s0_req_i & s0_bank;

  //////////////////////////////////////////////////////////////////////////
  // Requests reach a bank only for an acknowledged slot.
  //////////////////////////////////////////////////////////////////////////
  always_comb
  begin
    if (s0_owns_b0)
    begin
      bank0_o.req   = s0_ack_o;
      bank0_o.we    = s0_we_i;
      bank0_o.addr  = s0_addr_i;
      bank0_o.be    = s0_be_i;
      bank0_o.wdata = s0_wdata_i;
    end
    else
    begin
      bank0_o.req   = s1_ack_o & ~s1_bank;
      bank0_o.we    = s1_we_i;
      bank0_o.addr  = s1_addr_i;
      bank0_o.be    = s1_be_i;
      bank0_o.wdata = s1_wdata_i;
    end
  end

  always_comb
  begin
    if (s0_owns_b1)
    begin
      bank1_o.req   = s0_ack_o;
      bank1_o.we    = s0_we_i;
      bank1_o.addr  = s0_addr_i;
      bank1_o.be    = s0_be_i;
      bank1_o.wdata = s0_wdata_i;
    end
    else
    begin
      bank1_o.req   = s1_ack_o & s1_bank;
      bank1_o.we    = s1_we_i;
      bank1_o.addr  = s1_addr_i;
      bank1_o.be    = s1_be_i;
      bank1_o.wdata = s1_wdata_i;
    end
  end

  // Set bit means slot 1 issued the last access on that bank.
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      own_q <= 2'b00;
    else
    begin
      if (bank0_o.req)
        own_q[0] <= ~s0_owns_b0;
      if (bank1_o.req)
        own_q[1] <= ~s0_owns_b1;
    end
  end

  assign s0_resp_o  = (bank0_o.resp & ~own_q[0]) | (bank1_o.resp & ~own_q[1]);
  assign s1_resp_o  = (bank0_o.resp & own_q[0]) | (bank1_o.resp & own_q[1]);
  assign s0_rdata_o = (bank0_o.resp & ~own_q[0]) ? bank0_o.rdata : bank1_o.rdata;
  assign s1_rdata_o = (bank0_o.resp & own_q[0]) ? bank0_o.rdata : bank1_o.rdata;

  // A bank takes a request exactly when one slot is acknowledged on it.
  a_single_owner: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (bank0_o.req == ((s0_ack_o && !s0_bank) ^ (s1_ack_o && !s1_bank))) &&
    (bank1_o.req == ((s0_ack_o && s0_bank) ^ (s1_ack_o && s1_bank))))
    else $error("bank request does not match a single acknowledged slot");

endmodule

// File: hw/dpram_2bank_top.sv
`timescale 1ns/1ps
`include "dpram_defines.svh"

module dpram_2bank_top (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     bus0_slot0_req_i,
  input  logic                     bus0_slot0_we_i,
  input  logic [`DPRAM_ADDR_W-1:0] bus0_slot0_addr_i,
  input  logic [`DPRAM_BYTES-1:0]  bus0_slot0_be_i,
  input  logic [`DPRAM_DATA_W-1:0] bus0_slot0_wdata_i,
  output logic                     bus0_slot0_ack_o,
  output logic                     bus0_slot0_resp_o,
  output logic [`DPRAM_DATA_W-1:0] bus0_slot0_rdata_o,
  input  logic                     bus0_slot1_req_i,
  input  logic                     bus0_slot1_we_i,
  input  logic [`DPRAM_ADDR_W-1:0] bus0_slot1_addr_i,
  input  logic [`DPRAM_BYTES-1:0]  bus0_slot1_be_i,
  input  logic [`DPRAM_DATA_W-1:0] bus0_slot1_wdata_i,
  output logic                     bus0_slot1_ack_o,
  output logic                     bus0_slot1_resp_o,
  output logic [`DPRAM_DATA_W-1:0] bus0_slot1_rdata_o,
  input  logic                     bus1_slot0_req_i,
  input  logic                     bus1_slot0_we_i,
  input  logic [`DPRAM_ADDR_W-1:0] bus1_slot0_addr_i,
  input  logic [`DPRAM_BYTES-1:0]  bus1_slot0_be_i,
  input  logic [`DPRAM_DATA_W-1:0] bus1_slot0_wdata_i,
  output logic                     bus1_slot0_ack_o,
  output logic                     bus1_slot0_resp_o,
  output logic [`DPRAM_DATA_W-1:0] bus1_slot0_rdata_o,
  input  logic                     bus1_slot1_req_i,
  input  logic                     bus1_slot1_we_i,
  input  logic [`DPRAM_ADDR_W-1:0] bus1_slot1_addr_i,
  input  logic [`DPRAM_BYTES-1:0]  bus1_slot1_be_i,
  input  logic [`DPRAM_DATA_W-1:0] bus1_slot1_wdata_i,
  output logic                     bus1_slot1_ack_o,
  output logic                     bus1_slot1_resp_o,
  output logic [`DPRAM_DATA_W-1:0] bus1_slot1_rdata_o
);

  // Ports named by bus then bank, e.g. b1k0 is bus 1 on bank 0.
  logic [`DPRAM_ROW_W-1:0]  row_b0k0;
  logic [`DPRAM_ROW_W-1:0]  row_b0k1;
  logic [`DPRAM_ROW_W-1:0]  row_b1k0;
  logic [`DPRAM_ROW_W-1:0]  row_b1k1;
  logic                     we_b0k0;
  logic                     we_b0k1;
  logic                     we_b1k0;
  logic                     we_b1k1;
  logic [`DPRAM_DATA_W-1:0] wdata_b0k0;
  logic [`DPRAM_DATA_W-1:0] wdata_b0k1;
  logic [`DPRAM_DATA_W-1:0] wdata_b1k0;
  logic [`DPRAM_DATA_W-1:0] wdata_b1k1;
  logic [`DPRAM_DATA_W-1:0] rdata_b0k0;
  logic [`DPRAM_DATA_W-1:0] rdata_b0k1;
  logic [`DPRAM_DATA_W-1:0] rdata_b1k0;
  logic [`DPRAM_DATA_W-1:0] rdata_b1k1;

  bank_port_if if_b0k0 ();
  bank_port_if if_b0k1 ();
  bank_port_if if_b1k0 ();
  bank_port_if if_b1k1 ();

  ////////////////////////////////////////////////////////////////////////////
  // Bus routers.
  ////////////////////////////////////////////////////////////////////////////
  bus_router u_router0 (
    .clk_i      (clk_i),              .rst_n_i    (rst_n_i),
    .s0_req_i   (bus0_slot0_req_i),   .s0_we_i    (bus0_slot0_we_i),
    .s0_addr_i  (bus0_slot0_addr_i),  .s0_be_i    (bus0_slot0_be_i),
    .s0_wdata_i (bus0_slot0_wdata_i), .s0_ack_o   (bus0_slot0_ack_o),
    .s0_resp_o  (bus0_slot0_resp_o),  .s0_rdata_o (bus0_slot0_rdata_o),
    .s1_req_i   (bus0_slot1_req_i),   .s1_we_i    (bus0_slot1_we_i),
    .s1_addr_i  (bus0_slot1_addr_i),  .s1_be_i    (bus0_slot1_be_i),
    .s1_wdata_i (bus0_slot1_wdata_i), .s1_ack_o   (bus0_slot1_ack_o),
    .s1_resp_o  (bus0_slot1_resp_o),  .s1_rdata_o (bus0_slot1_rdata_o),
    .bank0_o    (if_b0k0.router),     .bank1_o    (if_b0k1.router)
  );

  bus_router u_router1 (
    .clk_i      (clk_i),              .rst_n_i    (rst_n_i),
    .s0_req_i   (bus1_slot0_req_i),   .s0_we_i    (bus1_slot0_we_i),
    .s0_addr_i  (bus1_slot0_addr_i),  .s0_be_i    (bus1_slot0_be_i),
    .s0_wdata_i (bus1_slot0_wdata_i), .s0_ack_o   (bus1_slot0_ack_o),
    .s0_resp_o  (bus1_slot0_resp_o),  .s0_rdata_o (bus1_slot0_rdata_o),
    .s1_req_i   (bus1_slot1_req_i),   .s1_we_i    (bus1_slot1_we_i),
    .s1_addr_i  (bus1_slot1_addr_i),  .s1_be_i    (bus1_slot1_be_i),
    .s1_wdata_i (bus1_slot1_wdata_i), .s1_ack_o   (bus1_slot1_ack_o),
    .s1_resp_o  (bus1_slot1_resp_o),  .s1_rdata_o (bus1_slot1_rdata_o),
    .bank0_o    (if_b1k0.router),     .bank1_o    (if_b1k1.router)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Port controllers.
  ////////////////////////////////////////////////////////////////////////////
  bank_port_ctrl u_ctrl_b0k0 (
    .clk_i (clk_i), .rst_n_i (rst_n_i), .port_i (if_b0k0.bank),
    .ram_row_o   (row_b0k0),   .ram_we_o    (we_b0k0),
    .ram_wdata_o (wdata_b0k0), .ram_rdata_i (rdata_b0k0)
  );

  bank_port_ctrl u_ctrl_b0k1 (
    .clk_i (clk_i), .rst_n_i (rst_n_i), .port_i (if_b0k1.bank),
    .ram_row_o   (row_b0k1),   .ram_we_o    (we_b0k1),
    .ram_wdata_o (wdata_b0k1), .ram_rdata_i (rdata_b0k1)
  );

  bank_port_ctrl u_ctrl_b1k0 (
    .clk_i (clk_i), .rst_n_i (rst_n_i), .port_i (if_b1k0.bank),
    .ram_row_o   (row_b1k0),   .ram_we_o    (we_b1k0),
    .ram_wdata_o (wdata_b1k0), .ram_rdata_i (rdata_b1k0)
  );

  bank_port_ctrl u_ctrl_b1k1 (
    .clk_i (clk_i), .rst_n_i (rst_n_i), .port_i (if_b1k1.bank),
    .ram_row_o   (row_b1k1),   .ram_we_o    (we_b1k1),
    .ram_wdata_o (wdata_b1k1), .ram_rdata_i (rdata_b1k1)
  );

  // Port A of each bank serves bus 0, port B serves bus 1.
  bank_ram u_bank0 (
    .clk_i     (clk_i),
    .a_row_i   (row_b0k0), .a_we_i (we_b0k0), .a_wdata_i (wdata_b0k0),
    .a_rdata_o (rdata_b0k0),
    .b_row_i   (row_b1k0), .b_we_i (we_b1k0), .b_wdata_i (wdata_b1k0),
    .b_rdata_o (rdata_b1k0)
  );

  bank_ram u_bank1 (
    .clk_i     (clk_i),
    .a_row_i   (row_b0k1), .a_we_i (we_b0k1), .a_wdata_i (wdata_b0k1),
    .a_rdata_o (rdata_b0k1),
    .b_row_i   (row_b1k1), .b_we_i (we_b1k1), .b_wdata_i (wdata_b1k1),
    .b_rdata_o (rdata_b1k1)
  );

endmodule

// File: testbench/tb_dpram.sv
`timescale 1ns/1ps
`include "dpram_defines.svh"

module tb_dpram;

  localparam int TEST_CYCLES = 400;
  localparam int TIMEOUT_NS  = TEST_CYCLES * 40 + 4000;

  logic                     clk_i = 1'b0;
  logic                     rst_n_i;
  logic [3:0]               req;
  logic [3:0]               we;
  logic [`DPRAM_ADDR_W-1:0] addr  [4];
  logic [`DPRAM_BYTES-1:0]  be    [4];
  logic [`DPRAM_DATA_W-1:0] wdata [4];
  logic [3:0]               ack;
  logic [3:0]               resp;
  logic [`DPRAM_DATA_W-1:0] rdata [4];

  // Shadow of the 64 words in use; busy bits indexed {bus, bank}.
  logic [31:0] shadow [64];
  logic [3:0]  busy_m;
  logic [3:0]  exp_ack;
  logic [3:0]  exp_resp;
  logic [31:0] exp_rdata [4];
  logic [31:0] lcg_state = 32'hf3fb_dec1;
  int          ack_errs = 0;
  int          resp_errs = 0;
  int          data_errs = 0;

  always #20 clk_i = ~clk_i;

  dpram_2bank_top u_dpram_2bank_top (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .bus0_slot0_req_i   (req[0]),
    .bus0_slot0_we_i    (we[0]),
    .bus0_slot0_addr_i  (addr[0]),
    .bus0_slot0_be_i    (be[0]),
    .bus0_slot0_wdata_i (wdata[0]),
    .bus0_slot0_ack_o   (ack[0]),
    .bus0_slot0_resp_o  (resp[0]),
    .bus0_slot0_rdata_o (rdata[0]),
    .bus0_slot1_req_i   (req[1]),
    .bus0_slot1_we_i    (we[1]),
    .bus0_slot1_addr_i  (addr[1]),
    .bus0_slot1_be_i    (be[1]),
    .bus0_slot1_wdata_i (wdata[1]),
    .bus0_slot1_ack_o   (ack[1]),
    .bus0_slot1_resp_o  (resp[1]),
    .bus0_slot1_rdata_o (rdata[1]),
    .bus1_slot0_req_i   (req[2]),
    .bus1_slot0_we_i    (we[2]),
    .bus1_slot0_addr_i  (addr[2]),
    .bus1_slot0_be_i    (be[2]),
    .bus1_slot0_wdata_i (wdata[2]),
    .bus1_slot0_ack_o   (ack[2]),
    .bus1_slot0_resp_o  (resp[2]),
    .bus1_slot0_rdata_o (rdata[2]),
    .bus1_slot1_req_i   (req[3]),
    .bus1_slot1_we_i    (we[3]),
    .bus1_slot1_addr_i  (addr[3]),
    .bus1_slot1_be_i    (be[3]),
    .bus1_slot1_wdata_i (wdata[3]),
    .bus1_slot1_ack_o   (ack[3]),
    .bus1_slot1_resp_o  (resp[3]),
    .bus1_slot1_rdata_o (rdata[3])
  );

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Enabled bytes move up by off lanes, anything past lane 3 is lost.
  function automatic logic [31:0] merge_word(logic [31:0] old, logic [31:0] data,
                                             logic [3:0] en, logic [1:0] off);
    logic [3:0]  en_up;
    logic [31:0] data_up;
    logic [31:0] word;
    en_up   = en << off;
    data_up = data << (8 * int'(off));
    word    = old;
    for (int k = 0; k < 4; k++)
    begin
      if (en_up[k])
        word[k*8 +: 8] = data_up[k*8 +: 8];
    end
    return word;
  endfunction

  // Slot 0 keeps its bank, slot 1 loses a clash, a busy bank takes nobody.
  function automatic logic [1:0] bus_acks(logic [1:0] r, logic [1:0] busy,
                                          logic bk0, logic bk1);
    logic [1:0] a;
    a[0] = r[0] & ~busy[bk0];
    a[1] = r[1] & ~busy[bk1] & ~(r[0] & (bk0 == bk1));
    return a;
  endfunction

  assign exp_ack[1:0] = bus_acks(req[1:0], busy_m[1:0], addr[0][2], addr[1][2]);
  assign exp_ack[3:2] = bus_acks(req[3:2], busy_m[3:2], addr[2][2], addr[3][2]);

  ////////////////////////////////////////////////////////////////////////////
  // Reference model, updated at every accepting edge.
  ////////////////////////////////////////////////////////////////////////////
  always @(posedge clk_i or negedge rst_n_i)
  begin
    logic [5:0] w;
    if (!rst_n_i)
    begin
      busy_m   <= 4'b0000;
      exp_resp <= 4'b0000;
    end
    else
    begin
      busy_m   <= 4'b0000;
      exp_resp <= 4'b0000;
      for (int s = 0; s < 4; s++)
      begin
        w = addr[s][7:2];
        if (exp_ack[s] && !we[s])
        begin
          exp_resp[s]  <= 1'b1;
          exp_rdata[s] <= shadow[w] >> (8 * int'(addr[s][1:0]));
        end
        else if (exp_ack[s] && (be[s] == 4'hf))
          shadow[w] <= wdata[s];
        else if (exp_ack[s])
        begin
          shadow[w] <= merge_word(shadow[w], wdata[s], be[s], addr[s][1:0]);
          busy_m[{s[1], addr[s][2]}] <= 1'b1;
        end
      end
    end
  end

  for (genvar s = 0; s < 4; s++)
  begin : g_check
    a_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i) ack[s] == exp_ack[s])
      else
      begin
        ack_errs++;
        $display("** Error at %0t: slot %0d ack %b, expected %b",
                 $time, s, $sampled(ack[s]), $sampled(exp_ack[s]));
      end

    a_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i) resp[s] == exp_resp[s])
      else
      begin
        resp_errs++;
        $display("** Error at %0t: slot %0d resp %b, expected %b",
                 $time, s, $sampled(resp[s]), $sampled(exp_resp[s]));
      end

    a_rdata: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !exp_resp[s] || (rdata[s] == exp_rdata[s]))
      else
      begin
        data_errs++;
        $display("** Error at %0t: slot %0d rdata %h, expected %h",
                 $time, s, $sampled(rdata[s]), $sampled(exp_rdata[s]));
      end
  end

  task automatic set_slot(input logic [1:0] s, input logic wr, input logic [5:0] word,
                          input logic [1:0] off, input logic [3:0] en,
                          input logic [31:0] data);
    req[s]   = 1'b1;
    we[s]    = wr;
    addr[s]  = {24'h0, word, off};
    be[s]    = en;
    wdata[s] = data;
  endtask

  // Each slot holds its request until it is acknowledged.
  task automatic run_slots();
    logic [3:0] acked;
    while (req != 4'b0000)
    begin
      @(negedge clk_i);
      acked = req & ack;
      @(posedge clk_i);
      #2;
      req = req & ~acked;
    end
  endtask

  task automatic rand_op(input logic [1:0] s, input logic [5:0] word);
    logic [31:0] r;
    r = next_rand();
    if (r[31])
      set_slot(s, 1'b0, word, r[27:26], 4'hf, 32'h0);
    else if (r[23:20] == 4'hf)
      set_slot(s, 1'b1, word, 2'b00, 4'hf, next_rand());
    else
      set_slot(s, 1'b1, word, r[27:26], r[23:20], next_rand());
  endtask

  // Bus b walks words 32*b up to 32*b+31, two banks per cycle.
  task automatic sweep(input logic wr, input logic rand_off);
    logic [31:0] r;
    for (int k = 0; k < 16; k++)
    begin
      for (int b = 0; b < 2; b++)
      begin
        r = next_rand();
        set_slot(2'(2*b), wr, 6'(32*b + 2*k), rand_off ? r[31:30] : 2'b00, 4'hf, r);
        set_slot(2'(2*b+1), wr, 6'(32*b + 2*k + 1), rand_off ? r[29:28] : 2'b00, 4'hf, ~r);
      end
      run_slots();
    end
  endtask

  initial
  begin
    logic [31:0] r;
    req = 4'b0000;
    we  = 4'b0000;
    for (int s = 0; s < 4; s++)
    begin
      addr[s]  = '0;
      be[s]    = '0;
      wdata[s] = '0;
    end
    rst_n_i = 1'b0;
    repeat (4) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;

    sweep(1'b1, 1'b0);
    sweep(1'b0, 1'b0);

    // Mixed traffic, each bus stays in its own half of the memory.
    repeat (60)
    begin
      for (int b = 0; b < 2; b++)
      begin
        r = next_rand();
        rand_op(2'(2*b), {b[0], r[30:26]});
        rand_op(2'(2*b+1), {b[0], r[24:20]});
      end
      run_slots();
    end

    // Partial write, then slot 1 on the same bank waits out the busy cycle.
    set_slot(2'd0, 1'b1, 6'd4, 2'd1, 4'b0110, next_rand());
    run_slots();
    set_slot(2'd1, 1'b0, 6'd4, 2'd0, 4'hf, 32'h0);
    run_slots();

    ////////////////////////////////////////////////////////////////////////////
    // Cross traffic, each bus reads what the other one wrote.
    ////////////////////////////////////////////////////////////////////////////
    for (int k = 0; k < 8; k++)
    begin
      set_slot(2'd0, 1'b1, 6'(2*k), 2'b00, 4'hf, next_rand());
      set_slot(2'd2, 1'b1, 6'(32 + 2*k), 2'b00, 4'hf, next_rand());
      run_slots();
      set_slot(2'd2, 1'b0, 6'(2*k), 2'b00, 4'hf, 32'h0);
      set_slot(2'd0, 1'b0, 6'(32 + 2*k), 2'b00, 4'hf, 32'h0);
      run_slots();
    end

    sweep(1'b0, 1'b1);
    repeat (2) @(posedge clk_i);

    $display("Errors: ack %0d, resp %0d, rdata %0d", ack_errs, resp_errs, data_errs);
    if ((ack_errs + resp_errs + data_errs) == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("Timeout: the test did not finish within %0d ns", TIMEOUT_NS);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: all.f
+incdir+hw
hw/dpram_pkg.sv
hw/bank_port_if.sv
hw/bank_ram.sv
hw/bank_port_ctrl.sv
hw/bus_router.sv
hw/dpram_2bank_top.sv
testbench/tb_dpram.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -f all.f --top-module tb_dpram -o tb_dpram \
  && ./obj_dir/tb_dpram > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
echo "Simulation passed"
exit 0
